// File: common/row_buf_pkg.sv
package row_buf_pkg;

    //////////////////////////////////////////////////
    // memory geometry
    //////////////////////////////////////////////////

    localparam int pixel_width   = 16;
    localparam int row_buf_depth = 512;
    localparam int addr_width    = $clog2(row_buf_depth);
    // one bank half holds one image row
    localparam int col_width     = addr_width - 1;

    typedef logic [pixel_width-1:0] pixel_t;
    typedef logic [addr_width-1:0]  buf_addr_t;
    typedef logic [col_width-1:0]   col_t;
    // last valid column at full address width
    typedef logic [addr_width-1:0]  num_cols_t;

    //////////////////////////////////////////////////
    // request and result bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       valid;
        logic [1:0] row;
        col_t       col;
        pixel_t     pixel;
    } prime_wr_t;

    typedef struct packed {
        logic   strobe;
        col_t   col;
        pixel_t pixel;
    } matric_wr_t;

    // odd bank pixel sits in the upper half
    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } window_pair_t;

    typedef struct packed {
        logic      wren;
        buf_addr_t addr;
        pixel_t    data;
    } bank_wr_t;

endpackage

// File: common/awe_ctrl_pkg.sv
package awe_ctrl_pkg;

    //////////////////////////////////////////////////
    // window engine controller view
    //////////////////////////////////////////////////

    // states of the external controller
    typedef enum logic [2:0] {
        st_idle,
        st_prim_buffer,
        st_wait_pfb_load,
        st_ce_active,
        st_wait_job_done,
        st_send_complete
    } awe_state_t;

    // pixel sequence word from the sequence memory
    typedef struct packed {
        logic              row_sel;
        row_buf_pkg::col_t col;
        logic              odd_adj;
    } pix_seq_t;

    // 3x3 window is walked in five steps
    localparam int cycle_count_max = 4;

    typedef logic [2:0] cycle_count_t;

endpackage

// File: hdl/pixel_ram_sdp.sv
`timescale 1ns/1ps

module pixel_ram_sdp
    import row_buf_pkg::*;
(
    input  logic      clk,
    input  bank_wr_t  wr,
    input  logic      rden,
    input  buf_addr_t rd_addr,
    output pixel_t    dout
);

    pixel_t mem [row_buf_depth];
    pixel_t mem_q;

    // single write port
    always_ff @(posedge clk) begin
        if (wr.wren) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // memory latch then output register
    always_ff @(posedge clk) begin
        if (rden) begin
            mem_q <= mem[rd_addr];
        end
        dout <= mem_q;
    end

endmodule

// File: row_buffer/row_buf_writer.sv
`timescale 1ns/1ps

module row_buf_writer
    import row_buf_pkg::*;
    import awe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  awe_state_t state,
    input  logic [1:0] gray_code,
    input  num_cols_t  num_cols,
    input  prime_wr_t  prime,
    input  matric_wr_t matric,
    input  logic       last_kernel,
    input  logic       move_one_row_down,
    input  logic       rst_addr,
    output bank_wr_t   even_wr,
    output bank_wr_t   odd_wr
);

    logic      prime_hit;
    logic      matric_go;
    logic      gray_even_par;
    buf_addr_t even_limit;
    buf_addr_t odd_limit;
    logic      matric_even;
    logic      matric_odd;

    //////////////////////////////////////////////////
    // request qualification
    //////////////////////////////////////////////////

    // priming only inside the row range
    assign prime_hit = (state == st_prim_buffer) && prime.valid &&
                       ({1'b0, prime.col} <= num_cols);

    assign matric_go = matric.strobe && (last_kernel || move_one_row_down);

    // 00 and 11 steer to the odd bank
    assign gray_even_par = ~^gray_code;

    assign even_limit = {gray_code[1], num_cols[col_width-1:0]};
    assign odd_limit  = {gray_code[0], num_cols[col_width-1:0]};

    // compare against the address written last
    assign matric_odd  = matric_go && gray_even_par && (odd_wr.addr < odd_limit);
    assign matric_even = matric_go && !gray_even_par && (even_wr.addr < even_limit);

    //////////////////////////////////////////////////
    // registered write ports
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            even_wr.wren <= 1'b0;
            even_wr.addr <= '0;
            odd_wr.wren  <= 1'b0;
            odd_wr.addr  <= '0;
        end else begin
            even_wr.wren <= 1'b0;
            odd_wr.wren  <= 1'b0;
            if (rst_addr) begin
                even_wr.addr <= '0;
                odd_wr.addr  <= '0;
            end
            if (prime_hit) begin
                case (prime.row)
                    // first row lands in both banks
                    2'd0: begin
                        even_wr.wren <= 1'b1;
                        even_wr.addr <= {1'b0, prime.col};
                        even_wr.data <= prime.pixel;
                        odd_wr.wren  <= 1'b1;
                        odd_wr.addr  <= {1'b0, prime.col};
                        odd_wr.data  <= prime.pixel;
                    end
                    2'd1: begin
                        odd_wr.wren <= 1'b1;
                        odd_wr.addr <= {1'b1, prime.col};
                        odd_wr.data <= prime.pixel;
                    end
                    2'd2: begin
                        even_wr.wren <= 1'b1;
                        even_wr.addr <= {1'b1, prime.col};
                        even_wr.data <= prime.pixel;
                    end
                    default: begin
                    end
                endcase
            end
            // incoming row overrides priming on the same bank
            if (matric_odd) begin
                odd_wr.wren <= 1'b1;
                odd_wr.addr <= {gray_code[0], matric.col};
                odd_wr.data <= matric.pixel;
            end
            if (matric_even) begin
                even_wr.wren <= 1'b1;
                even_wr.addr <= {gray_code[1], matric.col};
                even_wr.data <= matric.pixel;
            end
        end
    end

endmodule

// File: row_buffer/row_buf_reader.sv
`timescale 1ns/1ps

module row_buf_reader
    import row_buf_pkg::*;
    import awe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  awe_state_t   state,
    input  logic [1:0]   gray_code,
    input  logic         execute,
    input  pix_seq_t     seq,
    input  logic         move_one_row_down,
    output logic         rden,
    output buf_addr_t    even_rd_addr,
    output buf_addr_t    odd_rd_addr,
    input  pixel_t       even_dout,
    input  pixel_t       odd_dout,
    output window_pair_t pixel_dataout,
    output logic         dataout_valid,
    output cycle_count_t cycle_counter
);

    logic      rd_go;
    buf_addr_t even_addr_d;
    buf_addr_t odd_addr_d;
    logic      odd_col_lsb;
    logic [1:0] valid_pipe;
    logic [1:0] move_pipe;
    logic      move_incr;

    //////////////////////////////////////////////////
    // sequence word decode
    //////////////////////////////////////////////////

    assign rd_go = execute && (state == st_ce_active);

    // gray code flips the half select
    assign even_addr_d = {gray_code[1] ^ seq.row_sel, seq.col};

    assign odd_col_lsb = seq.col[0] | seq.odd_adj;
    assign odd_addr_d  = {gray_code[0] ^ seq.row_sel, seq.col[col_width-1:1], odd_col_lsb};

    always_ff @(posedge clk) begin
        if (rst) begin
            rden <= 1'b0;
        end else begin
            rden <= rd_go;
        end
    end

    // read addresses hold between strobes
    always_ff @(posedge clk) begin
        if (rd_go) begin
            even_rd_addr <= even_addr_d;
            odd_rd_addr  <= odd_addr_d;
        end
    end

    //////////////////////////////////////////////////
    // result marking
    //////////////////////////////////////////////////

    assign pixel_dataout = '{odd: odd_dout, even: even_dout};

    // two cycles match the memory read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
            move_pipe  <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], rden && !move_one_row_down};
            move_pipe  <= {move_pipe[0], rden && move_one_row_down};
        end
    end

    assign dataout_valid = valid_pipe[1];
    assign move_incr     = move_pipe[1];

    // window step counter idles at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
        end else if (dataout_valid || move_incr) begin
            if (cycle_counter == cycle_count_t'(cycle_count_max)) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end else begin
            cycle_counter <= '0;
        end
    end

endmodule

// File: row_buffer/awe_row_buffer.sv
`timescale 1ns/1ps

module awe_row_buffer
    import row_buf_pkg::*;
    import awe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  awe_state_t   state,
    input  logic [1:0]   gray_code,
    input  num_cols_t    num_cols,
    input  prime_wr_t    prime,
    input  matric_wr_t   matric,
    input  logic         last_kernel,
    input  logic         move_one_row_down,
    input  logic         rst_addr,
    input  logic         execute,
    input  pix_seq_t     seq,
    output window_pair_t pixel_dataout,
    output logic         dataout_valid,
    output cycle_count_t cycle_counter
);

    bank_wr_t  even_wr;
    bank_wr_t  odd_wr;
    logic      rden;
    buf_addr_t even_rd_addr;
    buf_addr_t odd_rd_addr;
    pixel_t    even_dout;
    pixel_t    odd_dout;

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////

    row_buf_writer writer_i (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .gray_code         (gray_code),
        .num_cols          (num_cols),
        .prime             (prime),
        .matric            (matric),
        .last_kernel       (last_kernel),
        .move_one_row_down (move_one_row_down),
        .rst_addr          (rst_addr),
        .even_wr           (even_wr),
        .odd_wr            (odd_wr)
    );

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////

    row_buf_reader reader_i (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .gray_code         (gray_code),
        .execute           (execute),
        .seq               (seq),
        .move_one_row_down (move_one_row_down),
        .rden              (rden),
        .even_rd_addr      (even_rd_addr),
        .odd_rd_addr       (odd_rd_addr),
        .even_dout         (even_dout),
        .odd_dout          (odd_dout),
        .pixel_dataout     (pixel_dataout),
        .dataout_valid     (dataout_valid),
        .cycle_counter     (cycle_counter)
    );

    // even and odd banks
    pixel_ram_sdp ram_even_i (
        .clk     (clk),
        .wr      (even_wr),
        .rden    (rden),
        .rd_addr (even_rd_addr),
        .dout    (even_dout)
    );

    pixel_ram_sdp ram_odd_i (
        .clk     (clk),
        .wr      (odd_wr),
        .rden    (rden),
        .rd_addr (odd_rd_addr),
        .dout    (odd_dout)
    );

endmodule

// File: verification/awe_row_buffer_checker.sv
`timescale 1ns/1ps

module awe_row_buffer_checker
    import awe_ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input awe_state_t   state,
    input logic         execute,
    input logic         move_one_row_down,
    input logic         dataout_valid,
    input cycle_count_t cycle_counter
);

    // counter wraps at four
    counter_range: assert property (@(posedge clk) disable iff (rst)
        cycle_counter <= cycle_count_t'(cycle_count_max))
        else $error("cycle_counter went past its wrap value");

    // valid result traces back to an execute strobe
    valid_origin: assert property (@(posedge clk) disable iff (rst)
        dataout_valid |-> $past(execute && (state == st_ce_active), 3) &&
                          !$past(move_one_row_down, 2))
        else $error("dataout_valid without a matching execute strobe");

    reset_clear: assert property (@(posedge clk) rst |=> !dataout_valid)
        else $error("dataout_valid high right after reset");

endmodule

// File: verification/awe_row_buffer_tb.sv
`timescale 1ns/1ps

module awe_row_buffer_tb
    import row_buf_pkg::*;
    import awe_ctrl_pkg::*;
();

    localparam int clk_period = 40;
    localparam int last_col   = 21;
    localparam int ncols      = last_col + 2;
    // rough cycle budget per test
    localparam int prime_len  = 2 * 3 * ncols + 10;
    localparam int read_len   = 4 * 2 * ncols + 4 * 12;
    localparam int matric_len = 4 * (ncols + 2 * ncols + 16);
    localparam int count_len  = 2 * 12 + 10;
    localparam int watchdog_cycles = prime_len + read_len + matric_len + count_len + 200;

    logic         clk;
    logic         rst;
    awe_state_t   state;
    logic [1:0]   gray_code;
    num_cols_t    num_cols;
    prime_wr_t    prime;
    matric_wr_t   matric;
    logic         last_kernel;
    logic         move_one_row_down;
    logic         rst_addr;
    logic         execute;
    pix_seq_t     seq;
    window_pair_t pixel_dataout;
    logic         dataout_valid;
    cycle_count_t cycle_counter;

    // bank reference model
    pixel_t       even_mem [row_buf_depth];
    pixel_t       odd_mem [row_buf_depth];
    buf_addr_t    even_last;
    buf_addr_t    odd_last;
    window_pair_t exp_q [$];
    string        test_name;

    always #(clk_period / 2) clk = ~clk;

    awe_row_buffer dut_i (.*);

    bind awe_row_buffer awe_row_buffer_checker checker_i (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .execute           (execute),
        .move_one_row_down (move_one_row_down),
        .dataout_valid     (dataout_valid),
        .cycle_counter     (cycle_counter)
    );

    //////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what,
                     expected, actual);
            stop_run();
        end
    endtask

    // every valid result is matched against the oldest prediction
    always @(negedge clk) begin
        window_pair_t expected;
        if (!rst && dataout_valid) begin
            if (exp_q.size() == 0) begin
                $display("dataout_valid went high with no read outstanding");
                stop_run();
            end else begin
                expected = exp_q.pop_front();
                check("pixel_dataout", expected, pixel_dataout);
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus and model updates
    //////////////////////////////////////////////////

    task automatic model_write(input logic odd_bank, input buf_addr_t addr, input pixel_t data);
        if (odd_bank) begin
            odd_mem[addr] = data;
            odd_last = addr;
        end else begin
            even_mem[addr] = data;
            even_last = addr;
        end
    endtask

    task automatic prime_pixel(input logic [1:0] row, input col_t col, input pixel_t data);
        prime = '{valid: 1'b1, row: row, col: col, pixel: data};
        if (state == st_prim_buffer && {1'b0, col} <= num_cols) begin
            if (row == 2'd0) begin
                model_write(1'b0, {1'b0, col}, data);
                model_write(1'b1, {1'b0, col}, data);
            end else if (row == 2'd1) begin
                model_write(1'b1, {1'b1, col}, data);
            end else if (row == 2'd2) begin
                model_write(1'b0, {1'b1, col}, data);
            end
        end
        @(negedge clk);
    endtask

    task automatic matric_pixel(input col_t col, input pixel_t data);
        buf_addr_t limit;
        matric = '{strobe: 1'b1, col: col, pixel: data};
        if (last_kernel || move_one_row_down) begin
            // even parity gray code steers to the odd bank
            if (gray_code[0] == gray_code[1]) begin
                limit = {gray_code[0], num_cols[col_width-1:0]};
                if (odd_last < limit) begin
                    model_write(1'b1, {gray_code[0], col}, data);
                end
            end else begin
                limit = {gray_code[1], num_cols[col_width-1:0]};
                if (even_last < limit) begin
                    model_write(1'b0, {gray_code[1], col}, data);
                end
            end
        end
        @(negedge clk);
    endtask

    task automatic drive_read(input logic row_sel, input col_t col, input logic odd_adj);
        buf_addr_t    ea;
        buf_addr_t    oa;
        window_pair_t pair;
        seq = '{row_sel: row_sel, col: col, odd_adj: odd_adj};
        execute = 1'b1;
        ea = {gray_code[1] ^ row_sel, col};
        oa = {gray_code[0] ^ row_sel, col[col_width-1:1], col[0] | odd_adj};
        pair.odd = odd_mem[oa];
        pair.even = even_mem[ea];
        if (state == st_ce_active && !move_one_row_down) begin
            exp_q.push_back(pair);
        end
    endtask

    task automatic drain_reads();
        int waited;
        waited = 0;
        execute = 1'b0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("read results still missing after %0d cycles", waited);
            stop_run();
        end
    endtask

    // back-to-back reads over both row selects
    task automatic read_sweep(input logic [1:0] gray, input logic odd_adj, input int cols);
        gray_code = gray;
        for (int rs = 0; rs < 2; rs++) begin
            for (int c = 0; c < cols; c++) begin
                drive_read(rs[0], col_t'(c), odd_adj);
                @(negedge clk);
            end
        end
        drain_reads();
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        test_name = "reset_state";
        check("dataout_valid", 32'(0), 32'(dataout_valid));
        check("cycle_counter", 32'(0), 32'(cycle_counter));
    endtask

    task automatic test_priming();
        test_name = "priming";
        state = st_prim_buffer;
        num_cols = num_cols_t'(last_col + 1);
        for (int row = 0; row < 3; row++) begin
            for (int c = 0; c <= last_col + 1; c++) begin
                prime_pixel(2'(row), col_t'(c), pixel_t'($urandom));
            end
        end
        // column past num_cols must be ignored
        num_cols = num_cols_t'(last_col);
        for (int row = 0; row < 3; row++) begin
            prime_pixel(2'(row), col_t'(last_col + 1), pixel_t'($urandom));
        end
        prime.valid = 1'b0;
        state = st_ce_active;
        repeat (2) @(negedge clk);
        read_sweep(2'b00, 1'b0, ncols);
    endtask

    task automatic test_gray_steering();
        test_name = "gray_steering";
        read_sweep(2'b01, 1'b1, last_col + 1);
        read_sweep(2'b11, 1'b1, last_col + 1);
        read_sweep(2'b10, 1'b1, last_col + 1);
    endtask

    task automatic test_matriculation();
        test_name = "matriculation";
        for (int g = 0; g < 4; g++) begin
            gray_code = 2'(g);
            rst_addr = 1'b1;
            even_last = '0;
            odd_last = '0;
            @(negedge clk);
            rst_addr = 1'b0;
            last_kernel = 1'b1;
            for (int c = 0; c <= last_col + 1; c++) begin
                matric_pixel(col_t'(c), pixel_t'($urandom));
            end
            matric.strobe = 1'b0;
            last_kernel = 1'b0;
            repeat (2) @(negedge clk);
            read_sweep(2'(g), 1'b0, ncols);
        end
    endtask

    task automatic test_cycle_counter();
        int exp_count [12] = '{0, 0, 0, 0, 1, 2, 3, 4, 0, 1, 2, 0};
        int move_count [9] = '{0, 0, 0, 0, 1, 2, 3, 0, 0};
        test_name = "cycle_counter";
        gray_code = 2'b00;
        repeat (2) @(negedge clk);
        for (int k = 0; k < 12; k++) begin
            check("cycle_counter", 32'(exp_count[k]), 32'(cycle_counter));
            check("dataout_valid", 32'(k >= 3 && k <= 9), 32'(dataout_valid));
            if (k < 7) begin
                drive_read(1'b0, col_t'(k), 1'b0);
            end else begin
                execute = 1'b0;
            end
            @(negedge clk);
        end
        drain_reads();
        // row move steps the counter without valid
        test_name = "row_move";
        move_one_row_down = 1'b1;
        repeat (2) @(negedge clk);
        for (int k = 0; k < 9; k++) begin
            check("cycle_counter", 32'(move_count[k]), 32'(cycle_counter));
            check("dataout_valid", 32'(0), 32'(dataout_valid));
            if (k < 3) begin
                drive_read(1'b0, col_t'(k), 1'b0);
            end else begin
                execute = 1'b0;
            end
            @(negedge clk);
        end
        move_one_row_down = 1'b0;
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        stop_run();
    end

    initial begin
        void'($urandom(32'h8aa257b8));
        clk = 1'b0;
        rst = 1'b1;
        state = st_idle;
        gray_code = 2'b00;
        num_cols = '0;
        prime = '0;
        matric = '0;
        last_kernel = 1'b0;
        move_one_row_down = 1'b0;
        rst_addr = 1'b0;
        execute = 1'b0;
        seq = '0;
        even_last = '0;
        odd_last = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_priming();
        test_gray_steering();
        test_matriculation();
        test_cycle_counter();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: project.f
common/row_buf_pkg.sv
common/awe_ctrl_pkg.sv
hdl/pixel_ram_sdp.sv
row_buffer/row_buf_writer.sv
row_buffer/row_buf_reader.sv
row_buffer/awe_row_buffer.sv
verification/awe_row_buffer_checker.sv
verification/awe_row_buffer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := awe_row_buffer_tb
FILE_LIST := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
